//--- rtl/rom_map_pkg.sv
/*
 * ROM map of the game download stream
 * byte address bases and lengths of the two PROM regions,
 * plus the region code the loader assigns to each byte
 */

package rom_map_pkg;

    // download byte address width
    localparam int DL_AW = 22;

    // character PROM image, 1 kB
    localparam logic [DL_AW-1:0] CHAR_BASE = 22'h02_0000;
    localparam logic [DL_AW-1:0] CHAR_SIZE = 22'd1024;

    // palette PROM image, 256 bytes
    // placed apart from the char region so a gap of skipped bytes sits between
    localparam logic [DL_AW-1:0] PAL_BASE  = 22'h02_8000;
    localparam logic [DL_AW-1:0] PAL_SIZE  = 22'd256;

    // where a strobed byte goes
    typedef enum logic [1:0] {
        REGION_NONE = 2'd0,
        REGION_CHAR = 2'd1,
        REGION_PAL  = 2'd2
    } region_t;

endpackage

//--- rtl/prom_cfg_pkg.sv
/*
 * PROM geometry and read clock enable setup
 * data and address widths of the char and palette PROMs,
 * and the clk to cen division ratio
 */

package prom_cfg_pkg;

    // character PROM, 8 bits x 1024
    localparam int CHAR_DW = 8;
    localparam int CHAR_AW = 10;

    // palette PROM, 4 bits x 256
    localparam int PAL_DW  = 4;
    localparam int PAL_AW  = 8;

    // clk cycles per read enable pulse
    localparam int CEN_DIV = 4;

    // divider counter width and terminal count
    localparam int CEN_CW  = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam logic [CEN_CW-1:0] CEN_LAST = CEN_CW'(CEN_DIV - 1);

endpackage

//--- rtl/prom.sv
/*
 * Synchronous PROM
 * write port runs every clk so the download can fill it
 * while the video side is stalled; read port is registered
 * and only advances on cen
 */

`timescale 1ns/100ps

module prom #(
    parameter int dw = 8,
    parameter int aw = 10
) (
    input  logic          clk,
    input  logic          cen,
    input  logic [dw-1:0] data,
    input  logic [aw-1:0] rd_addr,
    input  logic [aw-1:0] wr_addr,
    input  logic          we,
    output logic [dw-1:0] q
);

    // storage, contents undefined until downloaded
    logic [dw-1:0] mem [0:(2**aw)-1];

    // read side
    // q holds between enables
    // same-address collision returns the old word
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];
        end
    end

    // write side, not gated by cen
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

endmodule

//--- rtl/cen_gen.sv
/*
 * Read clock enable generator
 * one-cycle cen pulse every CEN_DIV clk cycles,
 * first pulse on the CEN_DIV-th cycle after reset
 */

`timescale 1ns/100ps

module cen_gen (
    input  logic clk,
    input  logic rst,
    output logic cen
);

    // phase within the period
    logic [prom_cfg_pkg::CEN_CW-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            cen <= 1'b0;
        end else begin
            // wrap at the terminal count
            if (cnt == prom_cfg_pkg::CEN_LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // registered pulse, so cen is glitch free for the PROMs
            cen <= (cnt == prom_cfg_pkg::CEN_LAST);
        end
    end

endmodule

//--- rtl/rom_loader.sv
/*
 * ROM download loader
 * decodes host byte writes against the ROM map, issues one
 * registered write per byte to the char or palette PROM,
 * keeps mod-256 checksums per region, counts skipped bytes
 * and flags the end of the download
 */

`timescale 1ns/100ps

module rom_loader (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              downloading,
    input  logic                              ioctl_wr,
    input  logic [rom_map_pkg::DL_AW-1:0]     ioctl_addr,
    input  logic [7:0]                        ioctl_dout,
    output logic                              char_we,
    output logic [prom_cfg_pkg::CHAR_AW-1:0]  char_wr_addr,
    output logic [prom_cfg_pkg::CHAR_DW-1:0]  char_data,
    output logic                              pal_we,
    output logic [prom_cfg_pkg::PAL_AW-1:0]   pal_wr_addr,
    output logic [prom_cfg_pkg::PAL_DW-1:0]   pal_data,
    output logic [7:0]                        char_sum,
    output logic [7:0]                        pal_sum,
    output logic [15:0]                       skip_cnt,
    output logic                              load_done
);

    rom_map_pkg::region_t region;

    // offsets into each region
    logic [rom_map_pkg::DL_AW-1:0] char_off;
    logic [rom_map_pkg::DL_AW-1:0] pal_off;

    // downloading edge detect
    logic dl_q;
    logic dl_rise;
    logic dl_fall;

    // status bases after a possible start-of-download clear
    logic [7:0]  char_sum_base;
    logic [7:0]  pal_sum_base;
    logic [15:0] skip_base;

    assign char_off = ioctl_addr - rom_map_pkg::CHAR_BASE;
    assign pal_off  = ioctl_addr - rom_map_pkg::PAL_BASE;

    assign dl_rise = downloading & ~dl_q;
    assign dl_fall = ~downloading & dl_q;

    // a byte strobed on the same cycle as the start still counts
    assign char_sum_base = dl_rise ? 8'd0  : char_sum;
    assign pal_sum_base  = dl_rise ? 8'd0  : pal_sum;
    assign skip_base     = dl_rise ? 16'd0 : skip_cnt;

    // map decode
    always_comb begin
        if (ioctl_addr >= rom_map_pkg::CHAR_BASE &&
            ioctl_addr <  rom_map_pkg::CHAR_BASE + rom_map_pkg::CHAR_SIZE) begin
            region = rom_map_pkg::REGION_CHAR;
        end else if (ioctl_addr >= rom_map_pkg::PAL_BASE &&
                     ioctl_addr <  rom_map_pkg::PAL_BASE + rom_map_pkg::PAL_SIZE) begin
            region = rom_map_pkg::REGION_PAL;
        end else begin
            region = rom_map_pkg::REGION_NONE;
        end
    end

    // write strobes and status
    always_ff @(posedge clk) begin
        if (rst) begin
            dl_q      <= 1'b0;
            char_we   <= 1'b0;
            pal_we    <= 1'b0;
            char_sum  <= 8'd0;
            pal_sum   <= 8'd0;
            skip_cnt  <= 16'd0;
            load_done <= 1'b0;
        end else begin
            dl_q    <= downloading;
            char_we <= ioctl_wr && region == rom_map_pkg::REGION_CHAR;
            pal_we  <= ioctl_wr && region == rom_map_pkg::REGION_PAL;

            // default: hold, or clear at the start
            char_sum <= char_sum_base;
            pal_sum  <= pal_sum_base;
            skip_cnt <= skip_base;

            if (ioctl_wr) begin
                case (region)
                    rom_map_pkg::REGION_CHAR: char_sum <= char_sum_base + ioctl_dout;
                    // palette keeps only the low nibble
                    rom_map_pkg::REGION_PAL:  pal_sum  <= pal_sum_base + {4'd0, ioctl_dout[3:0]};
                    default:                  skip_cnt <= skip_base + 16'd1;
                endcase
            end

            if (dl_rise) begin
                load_done <= 1'b0;
            end else if (dl_fall) begin
                load_done <= 1'b1;
            end
        end
    end

    // payload, follows every strobe
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            char_wr_addr <= char_off[prom_cfg_pkg::CHAR_AW-1:0];
            pal_wr_addr  <= pal_off[prom_cfg_pkg::PAL_AW-1:0];
            char_data    <= ioctl_dout;
            pal_data     <= ioctl_dout[3:0];
        end
    end

endmodule

//--- rtl/rom_sys.sv
/*
 * ROM download and graphics PROM subsystem
 * loader fills the char and palette PROMs from the host
 * byte stream; video side reads both under a shared cen
 */

`timescale 1ns/100ps

module rom_sys (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              downloading,
    input  logic                              ioctl_wr,
    input  logic [rom_map_pkg::DL_AW-1:0]     ioctl_addr,
    input  logic [7:0]                        ioctl_dout,
    input  logic [prom_cfg_pkg::CHAR_AW-1:0]  char_addr,
    input  logic [prom_cfg_pkg::PAL_AW-1:0]   pal_addr,
    output logic [prom_cfg_pkg::CHAR_DW-1:0]  char_q,
    output logic [prom_cfg_pkg::PAL_DW-1:0]   pal_q,
    output logic                              cen,
    output logic [7:0]                        char_sum,
    output logic [7:0]                        pal_sum,
    output logic [15:0]                       skip_cnt,
    output logic                              load_done
);

    // loader to char PROM
    logic                             char_we;
    logic [prom_cfg_pkg::CHAR_AW-1:0] char_wr_addr;
    logic [prom_cfg_pkg::CHAR_DW-1:0] char_data;

    // loader to palette PROM
    logic                             pal_we;
    logic [prom_cfg_pkg::PAL_AW-1:0]  pal_wr_addr;
    logic [prom_cfg_pkg::PAL_DW-1:0]  pal_data;

    rom_loader u_loader (
        .clk          (clk),
        .rst          (rst),
        .downloading  (downloading),
        .ioctl_wr     (ioctl_wr),
        .ioctl_addr   (ioctl_addr),
        .ioctl_dout   (ioctl_dout),
        .char_we      (char_we),
        .char_wr_addr (char_wr_addr),
        .char_data    (char_data),
        .pal_we       (pal_we),
        .pal_wr_addr  (pal_wr_addr),
        .pal_data     (pal_data),
        .char_sum     (char_sum),
        .pal_sum      (pal_sum),
        .skip_cnt     (skip_cnt),
        .load_done    (load_done)
    );

    // shared read enable for both PROMs
    cen_gen u_cen (
        .clk (clk),
        .rst (rst),
        .cen (cen)
    );

    prom #(
        .dw (prom_cfg_pkg::CHAR_DW),
        .aw (prom_cfg_pkg::CHAR_AW)
    ) u_char_prom (
        .clk     (clk),
        .cen     (cen),
        .data    (char_data),
        .rd_addr (char_addr),
        .wr_addr (char_wr_addr),
        .we      (char_we),
        .q       (char_q)
    );

    prom #(
        .dw (prom_cfg_pkg::PAL_DW),
        .aw (prom_cfg_pkg::PAL_AW)
    ) u_pal_prom (
        .clk     (clk),
        .cen     (cen),
        .data    (pal_data),
        .rd_addr (pal_addr),
        .wr_addr (pal_wr_addr),
        .we      (pal_we),
        .q       (pal_q)
    );

endmodule

//--- tb/rom_sys_chk.sv
/*
 * Bound protocol checks for rom_sys
 * read clock enable shape and period, loader write exclusivity
 * and load_done behavior while a download runs
 */

`timescale 1ns/100ps

module rom_sys_chk (
    input logic clk,
    input logic rst,
    input logic cen,
    input logic char_we,
    input logic pal_we,
    input logic downloading,
    input logic load_done
);

    // clk edges since the last sampled cen pulse
    logic seen_cen;
    int   since_cen;

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_cen  <= 1'b0;
            since_cen <= 0;
        end else if (cen) begin
            seen_cen  <= 1'b1;
            since_cen <= 1;
        end else begin
            since_cen <= since_cen + 1;
        end
    end

    // single-cycle pulse, never two in a row
    cen_one_cycle: assert property (@(posedge clk) disable iff (rst) cen |=> !cen)
        else $error("cen high on two consecutive cycles");

    // once running, cen comes back exactly every CEN_DIV cycles
    cen_period: assert property (@(posedge clk) disable iff (rst)
        seen_cen |-> (cen == (since_cen == prom_cfg_pkg::CEN_DIV)))
        else $error("cen period differs from CEN_DIV");

    // held low by reset
    cen_low_in_reset: assert property (@(posedge clk) rst |=> !cen)
        else $error("cen high after a reset cycle");

    // a byte goes to one PROM at most
    one_prom_write: assert property (@(posedge clk) disable iff (rst) !(char_we && pal_we))
        else $error("char and palette PROM written in the same cycle");

    // cleared one edge after downloading rises
    done_low_in_download: assert property (@(posedge clk) disable iff (rst)
        (downloading && $past(downloading)) |-> !load_done)
        else $error("load_done high during a download");

endmodule

bind rom_sys rom_sys_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .cen         (cen),
    .char_we     (char_we),
    .pal_we      (pal_we),
    .downloading (downloading),
    .load_done   (load_done)
);

//--- tb/rom_sys_scoreboard.sv
/*
 * Scoreboard for rom_sys
 * on each check strobe, samples the DUT output named by the
 * kind code at the falling edge and compares it with the value
 * the testbench took from the test file
 */

`timescale 1ns/100ps

module rom_sys_scoreboard (
    input  logic                             clk,
    input  logic                             chk_stb,
    input  logic [2:0]                       chk_kind,
    input  logic [15:0]                      chk_val,
    input  logic [prom_cfg_pkg::CHAR_DW-1:0] char_q,
    input  logic [prom_cfg_pkg::PAL_DW-1:0]  pal_q,
    input  logic [7:0]                       char_sum,
    input  logic [7:0]                       pal_sum,
    input  logic [15:0]                      skip_cnt,
    input  logic                             load_done,
    output int                               err_cnt,
    output int                               chk_cnt
);

    int          errs = 0;
    int          checks = 0;
    logic [15:0] act;
    string       name;

    assign err_cnt = errs;
    assign chk_cnt = checks;

    // falling edge, registered outputs are settled here
    always @(negedge clk) begin
        if (chk_stb) begin
            checks++;
            // kind codes: 0 char_q, 1 pal_q, 2 char_sum, 3 pal_sum,
            // 4 skip_cnt, 5 load_done
            case (chk_kind)
                3'd0: begin
                    name = "char_q";
                    act = {8'd0, char_q};
                end
                3'd1: begin
                    name = "pal_q";
                    act = {12'd0, pal_q};
                end
                3'd2: begin
                    name = "char_sum";
                    act = {8'd0, char_sum};
                end
                3'd3: begin
                    name = "pal_sum";
                    act = {8'd0, pal_sum};
                end
                3'd4: begin
                    name = "skip_cnt";
                    act = skip_cnt;
                end
                default: begin
                    name = "load_done";
                    act = {15'd0, load_done};
                end
            endcase
            if (chk_kind > 3'd5) begin
                $display("scoreboard got an unknown check kind %0d", chk_kind);
                errs++;
            end else if (act !== chk_val) begin
                $display("CHECK FAILED %s: actual 0x%h expected 0x%h", name, act, chk_val);
                errs++;
            end
        end
    end

endmodule

//--- tb/rom_sys_tb.sv
/*
 * Testbench top for rom_sys
 * runs the command list from the test file: download strobes,
 * PROM readback under cen and status checks after the download
 */

`timescale 1ns/100ps

module rom_sys_tb;

    localparam string TESTS_FILE = "tb/rom_sys_tests.txt";
    // timeout budget per command line, plus slack for reset and tail
    localparam int CYCLES_PER_LINE = 16;
    localparam int TIMEOUT_MARGIN = 200;
    // longest wait for cen or load_done
    localparam int WAIT_LIMIT = 64;

    logic                             clk;
    logic                             rst;
    logic                             downloading;
    logic                             ioctl_wr;
    logic [rom_map_pkg::DL_AW-1:0]    ioctl_addr;
    logic [7:0]                       ioctl_dout;
    logic [prom_cfg_pkg::CHAR_AW-1:0] char_addr;
    logic [prom_cfg_pkg::PAL_AW-1:0]  pal_addr;
    logic [prom_cfg_pkg::CHAR_DW-1:0] char_q;
    logic [prom_cfg_pkg::PAL_DW-1:0]  pal_q;
    logic                             cen;
    logic [7:0]                       char_sum;
    logic [7:0]                       pal_sum;
    logic [15:0]                      skip_cnt;
    logic                             load_done;

    // check request toward the scoreboard
    logic        chk_stb;
    logic [2:0]  chk_kind;
    logic [15:0] chk_val;
    int          err_cnt;
    int          chk_cnt;

    int run_errs = 0;
    int cycles = 0;
    int limit = 0;

    rom_sys u_dut (
        .clk (clk), .rst (rst), .downloading (downloading), .ioctl_wr (ioctl_wr),
        .ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout),
        .char_addr (char_addr), .pal_addr (pal_addr),
        .char_q (char_q), .pal_q (pal_q), .cen (cen),
        .char_sum (char_sum), .pal_sum (pal_sum),
        .skip_cnt (skip_cnt), .load_done (load_done)
    );

    rom_sys_scoreboard u_sb (
        .clk (clk), .chk_stb (chk_stb), .chk_kind (chk_kind), .chk_val (chk_val),
        .char_q (char_q), .pal_q (pal_q), .char_sum (char_sum), .pal_sum (pal_sum),
        .skip_cnt (skip_cnt), .load_done (load_done),
        .err_cnt (err_cnt), .chk_cnt (chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // run limit, armed once the command count is known
    initial begin
        wait (limit > 0);
        wait (cycles >= limit);
        $display("timeout after %0d cycles, the command list did not finish", cycles);
        $display("Testbench failed");
        $finish;
    end

    // next drive point, 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic request_check(input logic [2:0] kind, input logic [15:0] val);
        chk_stb = 1'b1;
        chk_kind = kind;
        chk_val = val;
        step();
        chk_stb = 1'b0;
    endtask

    task automatic write_byte(input logic [31:0] addr, input logic [31:0] data);
        ioctl_wr = 1'b1;
        ioctl_addr = addr[rom_map_pkg::DL_AW-1:0];
        ioctl_dout = data[7:0];
        step();
        ioctl_wr = 1'b0;
    endtask

    // present the address, let a pending write land, then catch a cen edge
    task automatic read_prom(input logic [7:0] region, input logic [31:0] addr,
                             input logic [31:0] expected);
        int n;
        if (region == "P") pal_addr = addr[prom_cfg_pkg::PAL_AW-1:0];
        else char_addr = addr[prom_cfg_pkg::CHAR_AW-1:0];
        step();
        n = 0;
        while (!cen && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!cen) begin
            $display("cen never pulsed while reading address 0x%h", addr);
            run_errs++;
        end else begin
            step();
            request_check((region == "P") ? 3'd1 : 3'd0, expected[15:0]);
        end
    endtask

    task automatic check_status(input logic [31:0] cs, input logic [31:0] ps,
                                input logic [31:0] sk);
        int n;
        n = 0;
        while (!load_done && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!load_done) begin
            $display("load_done did not rise after the download ended");
            run_errs++;
        end
        request_check(3'd2, cs[15:0]);
        request_check(3'd3, ps[15:0]);
        request_check(3'd4, sk[15:0]);
        request_check(3'd5, 16'd1);
    endtask

    function automatic bit is_command(input string line);
        byte c;
        if (line.len() == 0) return 1'b0;
        c = line.getc(0);
        return c == "W" || c == "B" || c == "E" || c == "R" || c == "S";
    endfunction

    initial begin
        int          fd;
        int          n;
        int          lines;
        string       line;
        logic [7:0]  cmd;
        logic [7:0]  region;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        rst = 1'b1;
        downloading = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = 8'd0;
        char_addr = '0;
        pal_addr = '0;
        chk_stb = 1'b0;
        chk_kind = 3'd0;
        chk_val = 16'd0;
        // first pass sizes the timeout
        lines = 0;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the test file %s", TESTS_FILE);
            run_errs++;
        end
        while (fd != 0 && $fgets(line, fd) > 0) begin
            if (is_command(line)) lines++;
        end
        if (fd != 0) $fclose(fd);
        limit = lines * CYCLES_PER_LINE + TIMEOUT_MARGIN;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        fd = (fd != 0) ? $fopen(TESTS_FILE, "r") : 0;
        while (fd != 0 && $fgets(line, fd) > 0) begin
            if (is_command(line)) begin
                cmd = line.getc(0);
                case (cmd)
                    "W": n = $sscanf(line, "%c %h %h", cmd, a1, a2) - 3;
                    "R": n = $sscanf(line, "%c %c %h %h", cmd, region, a1, a2) - 4;
                    "S": n = $sscanf(line, "%c %h %h %h", cmd, a1, a2, a3) - 4;
                    default: n = 0;
                endcase
                if (n != 0) begin
                    $display("malformed test line: %s", line);
                    run_errs++;
                end else begin
                    case (cmd)
                        "B": begin
                            downloading = 1'b1;
                            step();
                        end
                        "E": begin
                            downloading = 1'b0;
                            step();
                        end
                        "W": write_byte(a1, a2);
                        "R": read_prom(region, a1, a2);
                        default: check_status(a1, a2, a3);
                    endcase
                end
            end
        end
        if (fd != 0) $fclose(fd);
        repeat (4) step();
        $display("run done: %0d checks, %0d failed checks, %0d other errors",
                 chk_cnt, err_cnt, run_errs);
        if (err_cnt == 0 && run_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb/rom_sys_tests.txt
# one command per line, all numbers in hex
# W dl_addr byte | B | E | R C/P local_addr expected | S char_sum pal_sum skip_cnt
B
W 020000 5a
W 020001 a5
W 020002 3c
W 0203ff 81
W 028000 ac
W 028001 17
W 0280ff f3
R C 000 5a
R C 3ff 81
R P 00 c
W 01ffff 99
W 020400 77
W 028100 ee
R C 000 5a
R C 3ff 81
R P 00 c
E
S bc 16 3
R C 001 a5
R C 002 3c
R P 01 7
R P ff 3
B
W 020001 11
W 020010 22
W 020011 33
W 020012 44
W 028001 5d
W 028002 08
W 000000 00
E
S aa 15 1
R C 001 11
R C 010 22
R C 011 33
R C 012 44
R C 000 5a
R P 01 d
R P 02 8
R P 00 c

//--- all.f
rtl/rom_map_pkg.sv
rtl/prom_cfg_pkg.sv
rtl/prom.sv
rtl/cen_gen.sv
rtl/rom_loader.sv
rtl/rom_sys.sv
tb/rom_sys_chk.sv
tb/rom_sys_scoreboard.sv
tb/rom_sys_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rom_sys testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module rom_sys_tb \
    -Mdir obj_dir -o rom_sys_sim

./obj_dir/rom_sys_sim | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi
